// ==== test/epu_out_stim.txt ====
# W byte_addr len data... | R byte_addr len expected... | E enb | T test_no
# J word_base len shift read_beats read_addr expected... (read is issued during the job)
# Test 1 single beat
W 00000010 0 12345678
R 00000010 0 12345678
T 1
# Test 2 four beat bursts
W 00000040 3 a0000001 00000022 7fffffff 00001234
R 00000040 3 a0000001 00000022 7fffffff 00001234
R 00000044 1 00000022 7fffffff
T 2
# Test 3 job over words 32 to 39, shift 4
W 00000080 3 fffffff0 00000035 00123456 80000000
W 00000090 3 000fffff 00100000 0000abcd 7fffffff
J 20 7 04 0 00000000
R 00000080 3 00000000 00000003 0000ffff 00000000
R 00000090 3 0000ffff 0000ffff 00000abc 0000ffff
T 3
# Test 4 read waits behind a job on words 48 to 51, shift 1
W 000000c0 3 00000100 ffffffff 00020000 00000007
J 30 3 01 4 000000c0 00000080 00000000 0000ffff 00000003
T 4
# Test 5 host access switched off and back on
E 0
R 00000010 0 12345678
W 00000010 0 deadbeef
E 1
R 00000010 0 12345678
W 00000014 0 cafef00d
R 00000010 1 12345678 cafef00d
T 5

// ==== filelist.f ====
+incdir+hw
hw/epu_bus_pkg.sv
hw/epu_buf_pkg.sv
hw/epu_ifs.sv
hw/host_port.sv
hw/relu_engine.sv
hw/output_buffer_wrapper.sv
hw/result_sram.sv
hw/epu_out_top.sv
test/epu_out_properties.sv
test/epu_out_tb.sv

// ==== Bender.yml ====
package:
  name: epu_out

export_include_dirs:
  - hw

sources:
  - hw/epu_bus_pkg.sv
  - hw/epu_buf_pkg.sv
  - hw/epu_ifs.sv
  - hw/host_port.sv
  - hw/relu_engine.sv
  - hw/output_buffer_wrapper.sv
  - hw/result_sram.sv
  - hw/epu_out_top.sv
  - target: test
    files:
      - test/epu_out_properties.sv
      - test/epu_out_tb.sv

// ==== test/epu_out_tb.sv ====
`timescale 1ns/1ps

module epu_out_tb;
  import epu_bus_pkg::*;
  import epu_buf_pkg::*;

  logic       clk;
  logic       rst;
  logic       enb;
  logic       rd_req;
  logic       wr_req;
  host_addr_t addr;
  host_len_t  len;
  host_data_t wdata;
  logic       wdata_valid;
  logic       rvalid;
  host_data_t rdata;
  logic       start;
  buf_addr_t  job_base;
  buf_addr_t  job_len;
  logic [4:0] shift;
  logic       done;

  int         fd;
  int         scan;
  int         cycle = 0;
  int         limit = 0;
  int         errors = 0;
  int         tests = 0;
  // Read beats and the cycle each one was seen in
  host_data_t rd_q[$];
  int         rd_cyc_q[$];

  epu_out_top dut (
    .clk          (clk),
    .rst          (rst),
    .enb_i        (enb),
    .rd_req_i     (rd_req),
    .wr_req_i     (wr_req),
    .addr_i       (addr),
    .len_i        (len),
    .wdata_i      (wdata),
    .wdata_valid_i(wdata_valid),
    .rvalid_o     (rvalid),
    .rdata_o      (rdata),
    .start_i      (start),
    .job_base_i   (job_base),
    .job_len_i    (job_len),
    .shift_i      (shift),
    .done_o       (done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (rvalid) begin
      rd_q.push_back(rdata);
      rd_cyc_q.push_back(cycle);
    end
  end

  initial begin
    wait (limit > 0);
    while (cycle <= limit)
      @(negedge clk);
    $display("Run stopped at %0t after %0d cycles, stimulus did not complete", $time, cycle);
    $display("TEST FAILED");
    $finish;
  end

  task automatic skip_line;
    int c;
    c = $fgetc(fd);
    while (c != 10 && c != -1)
      c = $fgetc(fd);
  endtask

  // Waits for cnt beats, then a little longer to catch extra ones
  task automatic collect_beats(input int cnt);
    while (rd_q.size() < cnt)
      @(negedge clk);
    repeat (2) @(negedge clk);
    if (rd_q.size() != cnt) begin
      $display("Read returned %0d beats instead of %0d at %0t", rd_q.size(), cnt, $time);
      errors++;
    end
  endtask

  task automatic compare_beats(input host_addr_t a, input int cnt, input bit check);
    host_data_t exp;
    int         i;
    for (i = 0; i < cnt; i++) begin
      scan = $fscanf(fd, "%h", exp);
      if (check && i < rd_q.size() && rd_q[i] !== exp) begin
        $display("Error at %0t: addr %h expected %h got %h", $time, a + 4 * i, exp, rd_q[i]);
        errors++;
      end
      if (check && i > 0 && i < rd_q.size() && rd_cyc_q[i] - rd_cyc_q[i-1] != 2) begin
        $display("Read beat %0d came %0d cycles after the one before it",
                 i, rd_cyc_q[i] - rd_cyc_q[i-1]);
        errors++;
      end
    end
  endtask

  task automatic write_burst;
    host_addr_t a;
    host_data_t d;
    int         n;
    int         i;
    scan = $fscanf(fd, "%h %h", a, n);
    wr_req = 1'b1;
    addr   = a;
    len    = n;
    @(negedge clk);
    wr_req = 1'b0;
    for (i = 0; i <= n; i++) begin
      scan = $fscanf(fd, "%h", d);
      wdata       = d;
      wdata_valid = 1'b1;
      @(negedge clk);
    end
    wdata_valid = 1'b0;
    // IDLE, HOST_AW, then one HOST_W cycle per beat
    repeat (n + 4) @(negedge clk);
  endtask

  task automatic read_burst;
    host_addr_t a;
    int         n;
    scan = $fscanf(fd, "%h %h", a, n);
    rd_q.delete();
    rd_cyc_q.delete();
    rd_req = 1'b1;
    addr   = a;
    len    = n;
    @(negedge clk);
    rd_req = 1'b0;
    if (!enb) begin
      repeat (20) @(negedge clk);
      if (rd_q.size() != 0) begin
        $display("Read at %h returned data while host access was off", a);
        errors++;
      end
      compare_beats(a, n + 1, 1'b0);
    end else begin
      collect_beats(n + 1);
      compare_beats(a, n + 1, 1'b1);
    end
  endtask

  task automatic run_job;
    int         b;
    int         n;
    int         s;
    int         nrd;
    host_addr_t a;
    scan     = $fscanf(fd, "%h %h %h %h %h", b, n, s, nrd, a);
    job_base = b;
    job_len  = n;
    shift    = s;
    start    = 1'b1;
    rd_q.delete();
    rd_cyc_q.delete();
    if (nrd > 0) begin
      repeat (2) @(negedge clk);
      rd_req = 1'b1;
      addr   = a;
      len    = nrd - 1;
      @(negedge clk);
      rd_req = 1'b0;
    end
    while (!done)
      @(negedge clk);
    if (rd_q.size() != 0) begin
      $display("Host read was served before the job finished at %0t", $time);
      errors++;
    end
    // Wrapper releases the buffer on done with start still high
    repeat (2) @(negedge clk);
    if (!done) begin
      $display("done_o fell while start_i was still high at %0t", $time);
      errors++;
    end
    start = 1'b0;
    while (done)
      @(negedge clk);
    if (nrd > 0) begin
      collect_beats(nrd);
      compare_beats(a, nrd, 1'b1);
    end
  endtask

  initial begin
    logic [63:0] tok;
    int          n_cmd;
    int          n_words;
    int          b;
    int          v;
    int          test_errs;
    n_cmd       = 0;
    n_words     = 0;
    test_errs   = 0;
    rst         = 1'b1;
    enb         = 1'b1;
    rd_req      = 1'b0;
    wr_req      = 1'b0;
    addr        = '0;
    len         = '0;
    wdata       = '0;
    wdata_valid = 1'b0;
    start       = 1'b0;
    job_base    = '0;
    job_len     = '0;
    shift       = '0;

    // First pass sizes the cycle limit
    fd = $fopen("test/epu_out_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open test/epu_out_stim.txt");
      errors++;
    end
    while (fd != 0 && $fscanf(fd, "%s", tok) == 1) begin
      if (tok == "#") begin
        skip_line();
      end else if (tok == "J") begin
        n_cmd++;
        scan = $fscanf(fd, "%h %h", b, v);
        n_words += v + 1;
      end else if (tok == "W" || tok == "R" || tok == "E" || tok == "T") begin
        n_cmd++;
      end
    end
    if (fd != 0) begin
      $fclose(fd);
      fd = $fopen("test/epu_out_stim.txt", "r");
    end
    limit = 40 * n_cmd + 20 * n_words;

    repeat (4) @(negedge clk);
    rst = 1'b0;

    while (fd != 0 && $fscanf(fd, "%s", tok) == 1) begin
      if (tok == "#") begin
        skip_line();
      end else if (tok == "W") begin
        write_burst();
      end else if (tok == "R") begin
        read_burst();
      end else if (tok == "J") begin
        run_job();
      end else if (tok == "E") begin
        scan = $fscanf(fd, "%h", v);
        enb  = v[0];
        @(negedge clk);
      end else if (tok == "T") begin
        scan = $fscanf(fd, "%d", v);
        tests++;
        $display("Test %0d finished with %0d errors", v, errors - test_errs);
        test_errs = errors;
      end else begin
        $display("Unknown stimulus command %s", tok);
        errors++;
      end
    end

    $display("Summary: %0d tests run, %0d errors", tests, errors);
    if (errors == 0 && tests > 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== test/epu_out_properties.sv ====
`timescale 1ns/1ps
`include "epu_cfg_macros.svh"

module epu_out_properties (
  input logic                     clk,
  input logic                     rst,
  input epu_buf_pkg::wrap_state_e state_i,
  input logic                     rvalid_i,
  input logic                     mem_cs_i,
  input logic                     mem_w_req_i,
  input logic                     epu_cs_i,
  input logic                     epu_w_req_i,
  input logic                     arhns_i,
  input logic                     awhns_i
);
  import epu_buf_pkg::*;

  // A read beat always follows its SRAM read cycle
  rvalid_after_ar: assert property (@(posedge clk) disable iff (rst)
    rvalid_i |-> $past(state_i) == HOST_AR)
    else $error("rvalid_o without a HOST_AR cycle before it");

  // Read phases never write the buffer, and the engine never writes into them
  no_write_on_read: assert property (@(posedge clk) disable iff (rst)
    (state_i == HOST_AR || state_i == HOST_R) |->
      (!(mem_cs_i && mem_w_req_i == `EPU_WRITE_ENB) &&
       !(epu_cs_i && epu_w_req_i == `EPU_WRITE_ENB)))
    else $error("SRAM write during a host read");

  // Host requests stay pending while a job owns the buffer
  job_owns_sram: assert property (@(posedge clk) disable iff (rst)
    (state_i == EPU_RW && (arhns_i || awhns_i)) |=> (arhns_i || awhns_i))
    else $error("Host reached the SRAM during a job");

  idle_after_reset: assert property (@(posedge clk)
    $fell(rst) |=> state_i == IDLE)
    else $error("Wrapper not in IDLE after reset release");

endmodule

bind output_buffer_wrapper epu_out_properties u_props (
  .clk        (clk),
  .rst        (rst),
  .state_i    (state_q),
  .rvalid_i   (rvalid_o),
  .mem_cs_i   (mem.cs),
  .mem_w_req_i(mem.w_req),
  .epu_cs_i   (epu.cs),
  .epu_w_req_i(epu.w_req),
  .arhns_i    (req.arhns),
  .awhns_i    (req.awhns)
);

// ==== hw/epu_out_top.sv ====
`timescale 1ns/1ps

module epu_out_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    enb_i,
  // Host side
  input  logic                    rd_req_i,
  input  logic                    wr_req_i,
  input  epu_bus_pkg::host_addr_t addr_i,
  input  epu_bus_pkg::host_len_t  len_i,
  input  epu_bus_pkg::host_data_t wdata_i,
  input  logic                    wdata_valid_i,
  output logic                    rvalid_o,
  output epu_bus_pkg::host_data_t rdata_o,
  // Job control
  input  logic                    start_i,
  input  epu_buf_pkg::buf_addr_t  job_base_i,
  input  epu_buf_pkg::buf_addr_t  job_len_i,
  input  logic [4:0]              shift_i,
  output logic                    done_o
);
  sp_ram_if   epu_bus ();
  sp_ram_if   buf_bus ();
  host_req_if host_bus ();

  host_port u_host_port (
    .clk          (clk),
    .rst          (rst),
    .rd_req_i     (rd_req_i),
    .wr_req_i     (wr_req_i),
    .addr_i       (addr_i),
    .len_i        (len_i),
    .wdata_i      (wdata_i),
    .wdata_valid_i(wdata_valid_i),
    .req          (host_bus)
  );

  relu_engine u_relu_engine (
    .clk       (clk),
    .rst       (rst),
    .start_i   (start_i),
    .job_base_i(job_base_i),
    .job_len_i (job_len_i),
    .shift_i   (shift_i),
    .done_o    (done_o),
    .ram       (epu_bus)
  );

  output_buffer_wrapper u_wrapper (
    .clk     (clk),
    .rst     (rst),
    .enb_i   (enb_i),
    .start_i (start_i),
    .done_i  (done_o),
    .req     (host_bus),
    .epu     (epu_bus),
    .mem     (buf_bus),
    .rvalid_o(rvalid_o),
    .rdata_o (rdata_o)
  );

  result_sram u_result_sram (
    .clk(clk),
    .mem(buf_bus)
  );

endmodule

// ==== hw/result_sram.sv ====
`timescale 1ns/1ps
`include "epu_cfg_macros.svh"

module result_sram (
  input logic      clk,
  sp_ram_if.memory mem
);
  import epu_buf_pkg::*;

  localparam int unsigned DEPTH = 2 ** `EPU_BUF_AW;

  buf_word_t words [DEPTH];

  always_ff @(posedge clk) begin
    if (mem.cs && mem.w_req == `EPU_WRITE_ENB)
      words[mem.addr] <= mem.w_data;
    // Output register holds between reads
    if (mem.cs && mem.oe)
      mem.r_data <= words[mem.addr];
  end

endmodule

// ==== hw/output_buffer_wrapper.sv ====
`timescale 1ns/1ps
`include "epu_cfg_macros.svh"

module output_buffer_wrapper (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    enb_i,
  input  logic                    start_i,
  input  logic                    done_i,
  host_req_if.wrap                req,
  sp_ram_if.memory                epu,
  sp_ram_if.master                mem,
  output logic                    rvalid_o,
  output epu_bus_pkg::host_data_t rdata_o
);
  import epu_buf_pkg::*;

  wrap_state_e state_q;
  wrap_state_e state_d;
  buf_addr_t   host_word_addr;

  always_ff @(posedge clk, posedge rst) begin
    if (rst)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // A finished job still holding start must not re-enter
        if (start_i && !done_i)
          state_d = EPU_RW;
        else if (req.arhns)
          state_d = HOST_AR;
        else if (req.awhns)
          state_d = HOST_AW;
      end
      HOST_AR: state_d = enb_i ? HOST_R : IDLE;
      HOST_AW: state_d = enb_i ? HOST_W : IDLE;
      HOST_R:  state_d = req.rdfin ? IDLE : HOST_AR;
      HOST_W:  if (req.wrfin && req.whns) state_d = IDLE;
      EPU_RW:  if (done_i && start_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // Byte address to word address
  assign host_word_addr = req.addr[`EPU_BUF_AW+1:2];

  always_comb begin
    mem.cs     = 1'b0;
    mem.oe     = 1'b0;
    mem.addr   = host_word_addr;
    mem.w_req  = `EPU_WRITE_DIS;
    mem.w_data = req.wdata;
    case (state_q)
      EPU_RW: begin
        mem.cs     = epu.cs;
        mem.oe     = epu.oe;
        mem.addr   = epu.addr;
        mem.w_req  = epu.w_req;
        mem.w_data = epu.w_data;
      end
      HOST_AR: begin
        mem.cs = 1'b1;
        mem.oe = 1'b1;
      end
      HOST_W: begin
        mem.cs    = req.whns;
        mem.w_req = req.whns ? `EPU_WRITE_ENB : `EPU_WRITE_DIS;
      end
      default: ;
    endcase
  end

  assign epu.r_data = mem.r_data;

  // Registered read data shows up one cycle after HOST_AR
  assign rvalid_o = (state_q == HOST_R);
  assign rdata_o  = rvalid_o ? mem.r_data : '0;

  assign req.rhns = (state_q == HOST_R);
  assign req.wgnt = (state_q == HOST_W);
  assign req.acc  = (state_q == IDLE) && !(start_i && !done_i) &&
                    (req.arhns || req.awhns);

endmodule

// ==== hw/relu_engine.sv ====
`timescale 1ns/1ps
`include "epu_cfg_macros.svh"

module relu_engine (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start_i,
  input  epu_buf_pkg::buf_addr_t job_base_i,
  input  epu_buf_pkg::buf_addr_t job_len_i,
  input  logic [4:0]             shift_i,
  output logic                   done_o,
  sp_ram_if.master               ram
);
  import epu_buf_pkg::*;

  engine_state_e state_q;
  engine_state_e state_d;
  buf_addr_t     addr_q;
  buf_addr_t     left_q;
  buf_word_t     res_q;
  buf_word_t     shifted;
  buf_word_t     res_d;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state_q <= ENG_IDLE;
      addr_q  <= '0;
      left_q  <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == ENG_IDLE && start_i) begin
        addr_q <= job_base_i;
        left_q <= job_len_i;
      end else if (state_q == ENG_WR && left_q != '0) begin
        addr_q <= addr_q + 1'b1;
        left_q <= left_q - 1'b1;
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ENG_IDLE: if (start_i) state_d = ENG_RD;
      ENG_RD:   state_d = ENG_WAIT;
      ENG_WAIT: state_d = ENG_WR;
      ENG_WR:   state_d = (left_q == '0) ? ENG_DONE : ENG_RD;
      // Hold done until the start level drops
      ENG_DONE: if (!start_i) state_d = ENG_IDLE;
      default:  state_d = ENG_IDLE;
    endcase
  end

  // ReLU, logical shift, then clamp to 16 bits
  always_comb begin
    shifted = ram.r_data >> shift_i;
    if (ram.r_data[31])
      res_d = '0;
    else if (shifted > SAT_MAX)
      res_d = SAT_MAX;
    else
      res_d = shifted;
  end

  // Read data is valid in WAIT
  always_ff @(posedge clk) begin
    if (state_q == ENG_WAIT)
      res_q <= res_d;
  end

  always_comb begin
    ram.cs     = 1'b0;
    ram.oe     = 1'b0;
    ram.addr   = addr_q;
    ram.w_req  = `EPU_WRITE_DIS;
    ram.w_data = res_q;
    case (state_q)
      ENG_RD: begin
        ram.cs = 1'b1;
        ram.oe = 1'b1;
      end
      ENG_WR: begin
        ram.cs    = 1'b1;
        ram.w_req = `EPU_WRITE_ENB;
      end
      default: ;
    endcase
  end

  assign done_o = (state_q == ENG_DONE);

endmodule

// ==== hw/host_port.sv ====
`timescale 1ns/1ps
`include "epu_cfg_macros.svh"

module host_port (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    rd_req_i,
  input  logic                    wr_req_i,
  input  epu_bus_pkg::host_addr_t addr_i,
  input  epu_bus_pkg::host_len_t  len_i,
  input  epu_bus_pkg::host_data_t wdata_i,
  input  logic                    wdata_valid_i,
  host_req_if.port                req
);
  import epu_bus_pkg::*;

  logic       ar_pend_q;
  logic       aw_pend_q;
  logic       rd_run_q;
  logic       wr_run_q;
  host_len_t  rd_left_q;
  host_len_t  wr_len_q;
  host_len_t  wr_cnt_q;
  host_len_t  wr_idx_q;
  host_addr_t rd_addr_q;
  host_addr_t wr_addr_q;
  host_data_t wbuf_q [`EPU_MAX_BURST];

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      ar_pend_q <= 1'b0;
      aw_pend_q <= 1'b0;
      rd_run_q  <= 1'b0;
      wr_run_q  <= 1'b0;
      rd_left_q <= '0;
      wr_len_q  <= '0;
      wr_cnt_q  <= '0;
      wr_idx_q  <= '0;
    end else begin
      if (rd_req_i) begin
        ar_pend_q <= 1'b1;
        rd_run_q  <= 1'b0;
        rd_left_q <= len_i;
      end else begin
        // Read wins when both are pending, same as the wrapper
        if (req.acc && ar_pend_q) begin
          ar_pend_q <= 1'b0;
          rd_run_q  <= 1'b1;
        end
        if (req.rhns) begin
          rd_left_q <= rd_left_q - 1'b1;
          if (req.rdfin)
            rd_run_q <= 1'b0;
        end
      end

      if (wr_req_i) begin
        aw_pend_q <= 1'b0;
        wr_run_q  <= 1'b0;
        wr_len_q  <= len_i;
        wr_cnt_q  <= '0;
        wr_idx_q  <= '0;
      end else begin
        // Address phase only once every beat is stored
        if (wdata_valid_i) begin
          wr_cnt_q <= wr_cnt_q + 1'b1;
          if (wr_cnt_q == wr_len_q)
            aw_pend_q <= 1'b1;
        end
        if (req.acc && !ar_pend_q && aw_pend_q) begin
          aw_pend_q <= 1'b0;
          wr_run_q  <= 1'b1;
        end
        if (req.whns) begin
          wr_idx_q <= wr_idx_q + 1'b1;
          if (req.wrfin)
            wr_run_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wdata_valid_i)
      wbuf_q[wr_cnt_q] <= wdata_i;
    if (rd_req_i)
      rd_addr_q <= addr_i;
    else if (req.rhns)
      rd_addr_q <= rd_addr_q + HOST_BEAT_BYTES;
    if (wr_req_i)
      wr_addr_q <= addr_i;
    else if (req.whns)
      wr_addr_q <= wr_addr_q + HOST_BEAT_BYTES;
  end

  assign req.arhns = ar_pend_q;
  assign req.awhns = aw_pend_q;
  assign req.rdfin = rd_run_q && (rd_left_q == '0);
  assign req.whns  = req.wgnt && wr_run_q;
  assign req.wrfin = wr_run_q && (wr_idx_q == wr_len_q);
  assign req.addr  = req.wgnt ? wr_addr_q : rd_addr_q;
  assign req.wdata = wbuf_q[wr_idx_q];

endmodule

// ==== hw/epu_ifs.sv ====
`timescale 1ns/1ps

interface sp_ram_if;
  import epu_buf_pkg::*;

  logic      cs;
  logic      oe;
  buf_addr_t addr;
  logic      w_req;
  buf_word_t w_data;
  buf_word_t r_data;

  modport master (
    output cs, oe, addr, w_req, w_data,
    input  r_data
  );

  modport memory (
    input  cs, oe, addr, w_req, w_data,
    output r_data
  );
endinterface

interface host_req_if;
  import epu_bus_pkg::*;

  logic       arhns;
  logic       awhns;
  logic       whns;
  logic       rdfin;
  logic       wrfin;
  host_addr_t addr;
  host_data_t wdata;
  logic       rhns;
  // Wrapper takes a pending request out of IDLE
  logic       acc;
  // Wrapper sits in the write beat state
  logic       wgnt;

  modport port (
    output arhns, awhns, whns, rdfin, wrfin, addr, wdata,
    input  rhns, acc, wgnt
  );

  modport wrap (
    input  arhns, awhns, whns, rdfin, wrfin, addr, wdata,
    output rhns, acc, wgnt
  );
endinterface

// ==== hw/epu_buf_pkg.sv ====
`include "epu_cfg_macros.svh"

package epu_buf_pkg;

  typedef logic [`EPU_BUF_AW-1:0] buf_addr_t;
  typedef logic [31:0]            buf_word_t;

  // Largest value left after post-processing
  localparam buf_word_t SAT_MAX = 32'h0000_ffff;

  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    EPU_RW  = 3'd1,
    HOST_AR = 3'd2,
    HOST_AW = 3'd3,
    HOST_R  = 3'd4,
    HOST_W  = 3'd5
  } wrap_state_e;

  typedef enum logic [2:0] {
    ENG_IDLE = 3'd0,
    ENG_RD   = 3'd1,
    ENG_WAIT = 3'd2,
    ENG_WR   = 3'd3,
    ENG_DONE = 3'd4
  } engine_state_e;

endpackage

// ==== hw/epu_bus_pkg.sv ====
`include "epu_cfg_macros.svh"

package epu_bus_pkg;

  // Byte address as seen by the host
  typedef logic [31:0] host_addr_t;

  typedef logic [31:0] host_data_t;

  // Beats minus one
  typedef logic [$clog2(`EPU_MAX_BURST)-1:0] host_len_t;

  // Address step between beats
  localparam host_addr_t HOST_BEAT_BYTES = 32'd4;

endpackage

// ==== hw/epu_cfg_macros.svh ====
`ifndef EPU_CFG_MACROS_SVH
`define EPU_CFG_MACROS_SVH

// Result buffer geometry, 256 words
`define EPU_BUF_AW 8

// Longest host burst in beats
`define EPU_MAX_BURST 4

// Write request levels on the SRAM port
`define EPU_WRITE_ENB 1'b1
`define EPU_WRITE_DIS 1'b0

`endif
